// ==== block_aligner.sv ====
// ==============================
// block aligner
// cuts a 66-bit block out of two words
// ==============================
`timescale 1ns/1ns
`default_nettype none

module block_aligner (
    input  wire                       i_clk,
    input  wire                       i_reset,
    input  wire pcs_rx_pkg::raw_word_t i_word,
    input  wire                       i_word_valid,
    input  wire                       i_slip,
    output pcs_rx_pkg::block_t        o_block,
    output logic                      o_block_valid
);

    import pcs_rx_pkg::*;

    // bit 0 of a word is the first bit off the wire
    raw_word_t              prev_word;
    slip_offset_t           offset;
    logic [2*BLOCK_W-1:0]   word_pair;
    logic [2*BLOCK_W-1:0]   shifted;
    raw_word_t              window;

    // older word in the low half, so the pair reads in arrival order from bit 0 up
    assign word_pair = {i_word, prev_word};
    // window starts offset bits into the older word and runs into the newer one
    assign shifted = word_pair >> offset;
    assign window  = shifted[BLOCK_W-1:0];

    // this stands in for the bit slip a real serdes would do
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            offset <= '0;
        end else if (i_slip) begin
            // wraps after the last bit position of a block
            if (offset == slip_offset_t'(BLOCK_W - 1)) begin
                offset <= '0;
            end else begin
                offset <= offset + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            prev_word     <= '0;
            o_block_valid <= 1'b0;
        end else begin
            o_block_valid <= i_word_valid;
            if (i_word_valid) begin
                prev_word <= i_word;
            end
        end
    end

    // header bits arrive first, then the payload LSB first
    always_ff @(posedge i_clk) begin
        if (i_word_valid) begin
            o_block.header  <= window[HEADER_W-1:0];
            o_block.payload <= window[BLOCK_W-1:HEADER_W];
        end
    end

endmodule

`default_nettype wire

// ==== descrambler.sv ====
// ==============================
// payload descrambler
// self-synchronizing, 1 + x^39 + x^58
// ==============================
`timescale 1ns/1ns
`default_nettype none

module descrambler (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire pcs_rx_pkg::block_t i_block,
    input  wire                    i_valid,
    input  wire                    i_bypass,
    output pcs_rx_pkg::block_t     o_block,
    output logic                   o_valid
);

    import pcs_rx_pkg::*;

    localparam int HIST_W = 58;
    localparam int TAP_A  = 39;
    localparam int TAP_B  = 58;

    // history holds the last 58 scrambled bits, bit HIST_W-1 is the newest
    logic [HIST_W-1:0]           history;
    logic [HIST_W+PAYLOAD_W-1:0] stream;
    payload_t                    descrambled;

    // history below the payload gives one continuous bit stream in arrival order
    assign stream = {i_block.payload, history};

    // each bit is the received bit xor the received bits 39 and 58 before it
    always_comb begin
        for (int i = 0; i < PAYLOAD_W; i++) begin
            descrambled[i] = stream[HIST_W+i] ^ stream[HIST_W+i-TAP_A] ^ stream[HIST_W+i-TAP_B];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // the history keeps running in bypass too, so leaving bypass needs no resync
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            history         <= stream[HIST_W+PAYLOAD_W-1:PAYLOAD_W];
            o_block.header  <= i_block.header;
            o_block.payload <= i_bypass ? i_block.payload : descrambled;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
pcs_rx_pkg.sv
block_aligner.sv
lock_fsm.sv
descrambler.sv
pcs_rx_regs.sv
pcs_rx_top.sv
pcs_rx_checker.sv
tb_pcs_rx.sv

// ==== lock_fsm.sv ====
// ==============================
// block lock state machine
// clause 49 sync header lock and slip
// ==============================
`timescale 1ns/1ns
`default_nettype none

module lock_fsm #(
    parameter int GOOD_HDR_COUNT = 64,
    parameter int BAD_HDR_LIMIT  = 16
) (
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire pcs_rx_pkg::header_t i_header,
    input  wire                     i_valid,
    output logic                    o_slip,
    output logic                    o_block_lock,
    output logic                    o_bad_hdr
);

    import pcs_rx_pkg::*;

    localparam int CNT_W = $clog2(GOOD_HDR_COUNT + 1);
    localparam int INV_W = $clog2(BAD_HDR_LIMIT + 1);

    typedef enum logic [2:0] {
        LOCK_INIT,
        RESET_CNT,
        TEST_SH,
        VALID_SH,
        INVALID_SH,
        GOOD_64,
        SLIP
    } lock_state_t;

    lock_state_t      state;
    lock_state_t      next_state;
    logic [CNT_W-1:0] sh_cnt;
    logic [CNT_W-1:0] sh_cnt_next;
    logic [INV_W-1:0] sh_invalid_cnt;
    logic [INV_W-1:0] sh_invalid_next;
    logic             sh_valid;
    logic             counting;
    logic             take;
    logic             window_done;
    logic             limit_hit;

    assign sh_valid = (i_header == HDR_DATA) || (i_header == HDR_CTRL);

    // headers are only judged in the four counting states and only on a strobe,
    // everything else holds so no header is lost while the input idles
    assign counting = (state == TEST_SH) || (state == VALID_SH) ||
                      (state == INVALID_SH) || (state == GOOD_64);
    assign take     = counting && i_valid;

    // counts as they would be after the header on the input is taken
    assign sh_cnt_next     = sh_cnt + 1'b1;
    assign sh_invalid_next = sh_invalid_cnt + INV_W'(!sh_valid);
    assign window_done     = (sh_cnt_next == CNT_W'(GOOD_HDR_COUNT));
    assign limit_hit       = (sh_invalid_next == INV_W'(BAD_HDR_LIMIT));

    // SLIP lasts one cycle, which makes this the slip pulse to the aligner
    assign o_slip = (state == SLIP);

    always_comb begin
        next_state = state;
        case (state)
            LOCK_INIT: begin
                next_state = RESET_CNT;
            end
            // the blocks seen in SLIP and RESET_CNT were cut at the old offset
            RESET_CNT: begin
                next_state = TEST_SH;
            end
            SLIP: begin
                next_state = RESET_CNT;
            end
            TEST_SH, VALID_SH, INVALID_SH, GOOD_64: begin
                if (take) begin
                    if (limit_hit) begin
                        next_state = SLIP;
                    end else if (window_done) begin
                        // a clean window locks, a window with a few bad headers just restarts
                        next_state = (sh_invalid_next == '0) ? GOOD_64 : TEST_SH;
                    end else begin
                        next_state = sh_valid ? VALID_SH : INVALID_SH;
                    end
                end
            end
            default: begin
                next_state = LOCK_INIT;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= LOCK_INIT;
            sh_cnt         <= '0;
            sh_invalid_cnt <= '0;
            o_block_lock   <= 1'b0;
            o_bad_hdr      <= 1'b0;
        end else begin
            state     <= next_state;
            o_bad_hdr <= take && !sh_valid;
            // counters restart at every window end and after every slip
            if (state == RESET_CNT) begin
                sh_cnt         <= '0;
                sh_invalid_cnt <= '0;
            end else if (take) begin
                if (window_done || limit_hit) begin
                    sh_cnt         <= '0;
                    sh_invalid_cnt <= '0;
                end else begin
                    sh_cnt         <= sh_cnt_next;
                    sh_invalid_cnt <= sh_invalid_next;
                end
            end
            // lock is set going into GOOD_64 and only a slip takes it away
            if (next_state == GOOD_64) begin
                o_block_lock <= 1'b1;
            end else if ((next_state == SLIP) || (next_state == LOCK_INIT)) begin
                o_block_lock <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pcs_rx_checker.sv ====
// ==============================
// receive pcs output checker
// compares blocks with the stream model
// ==============================
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_checker (
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_word_valid,
    input  wire pcs_rx_pkg::block_t i_block,
    input  wire                     i_block_valid,
    input  wire                     i_block_lock,
    input  wire                     i_bypass_mode,
    output int                      o_errors,
    output int                      o_checked,
    output int                      o_count,
    output int                      o_lock_idx
);

    import pcs_rx_pkg::*;

    // expected blocks by block index in plain form and as scrambled on the line
    block_t exp_plain[$];
    block_t exp_scr[$];
    logic   prev_lock;
    // input strobe as seen one and two clock edges back
    logic   word_valid_d1;
    logic   word_valid_d2;

    // the stream model hands over every block it puts on the line
    task automatic add_expected(input block_t plain, input block_t scr);
        exp_plain.push_back(plain);
        exp_scr.push_back(scr);
    endtask

    // the n-th output strobe comes from input word n, which closes block n-1
    // at the aligned offset, so the block index is the strobe count minus one
    always @(negedge i_clk) begin : sample
        block_t exp_b;
        int     idx;
        logic   bad;
        idx = o_count - 1;
        bad = 1'b0;
        if (i_reset) begin
            o_errors      <= 0;
            o_checked     <= 0;
            o_count       <= 0;
            o_lock_idx    <= -1;
            prev_lock     <= 1'b0;
            word_valid_d1 <= 1'b0;
            word_valid_d2 <= 1'b0;
        end else begin
            // the output strobe trails the input strobe by exactly two edges
            if (i_block_valid !== word_valid_d2) begin
                $display("[ERROR] o_block_valid exp 0x%h got 0x%h",
                         word_valid_d2, i_block_valid);
                bad = 1'b1;
            end
            word_valid_d1 <= i_word_valid;
            word_valid_d2 <= word_valid_d1;
            if (i_block_valid) begin
                // lock came up here and the lock window phase starts from this block
                if (i_block_lock && !prev_lock) begin
                    o_lock_idx <= idx;
                end
                // the first block under lock is skipped while the history settles
                if (i_block_lock && prev_lock && (idx >= 0)) begin
                    if (idx >= exp_plain.size()) begin
                        $display("block %0d came out but the model never produced it", idx);
                        bad = 1'b1;
                    end else begin
                        exp_b = i_bypass_mode ? exp_scr[idx] : exp_plain[idx];
                        if (i_block.header !== exp_b.header) begin
                            $display("[ERROR] o_block.header block %0d exp 0x%h got 0x%h",
                                     idx, exp_b.header, i_block.header);
                            bad = 1'b1;
                        end
                        if (i_block.payload !== exp_b.payload) begin
                            $display("[ERROR] o_block.payload block %0d exp 0x%h got 0x%h",
                                     idx, exp_b.payload, i_block.payload);
                            bad = 1'b1;
                        end
                    end
                    o_checked <= o_checked + 1;
                end
                prev_lock <= i_block_lock;
                o_count   <= o_count + 1;
            end
            if (bad) begin
                o_errors <= o_errors + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== pcs_rx_pkg.sv ====
// ==============================
// pcs receive shared types
// widths, block struct, register map
// ==============================
`default_nettype none

package pcs_rx_pkg;

    // a 64b/66b block is a 2-bit sync header followed by a 64-bit payload
    localparam int HEADER_W   = 2;
    localparam int PAYLOAD_W  = 64;
    localparam int BLOCK_W    = HEADER_W + PAYLOAD_W;
    // offset has to cover 0..65, so 7 bits
    localparam int OFFSET_W   = 7;
    localparam int REG_ADDR_W = 2;
    localparam int REG_DATA_W = 16;

    typedef logic [HEADER_W-1:0]   header_t;
    typedef logic [PAYLOAD_W-1:0]  payload_t;
    typedef logic [BLOCK_W-1:0]    raw_word_t;
    typedef logic [OFFSET_W-1:0]   slip_offset_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [REG_DATA_W-1:0] reg_data_t;

    // header sits above the payload, so header is bits [65:64] of the packed block
    typedef struct packed {
        header_t  header;
        payload_t payload;
    } block_t;

    // only these two sync headers are legal and 00 or 11 is a line error
    localparam header_t HDR_DATA = 2'b01;
    localparam header_t HDR_CTRL = 2'b10;

    // register map
    localparam reg_addr_t REG_CTRL        = 2'd0;
    localparam reg_addr_t REG_STATUS      = 2'd1;
    localparam reg_addr_t REG_SLIP_CNT    = 2'd2;
    localparam reg_addr_t REG_BAD_HDR_CNT = 2'd3;

endpackage

`default_nettype wire

// ==== pcs_rx_regs.sv ====
// ==============================
// pcs receive register block
// bypass control, lock and counters
// ==============================
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_regs (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire                        i_reg_wr,
    input  wire                        i_reg_rd,
    input  wire pcs_rx_pkg::reg_addr_t  i_reg_addr,
    input  wire pcs_rx_pkg::reg_data_t  i_reg_wdata,
    output pcs_rx_pkg::reg_data_t      o_reg_rdata,
    input  wire                        i_block_lock,
    input  wire                        i_slip,
    input  wire                        i_bad_hdr,
    output logic                       o_bypass
);

    import pcs_rx_pkg::*;

    reg_data_t slip_cnt;
    reg_data_t bad_hdr_cnt;
    reg_data_t rd_mux;

    // only bit 0 of REG_CTRL is implemented, the rest reads back as zero
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bypass <= 1'b0;
        end else if (i_reg_wr && (i_reg_addr == REG_CTRL)) begin
            o_bypass <= i_reg_wdata[0];
        end
    end

    // both counters stick at all ones instead of wrapping
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            slip_cnt    <= '0;
            bad_hdr_cnt <= '0;
        end else begin
            if (i_slip && (slip_cnt != '1)) begin
                slip_cnt <= slip_cnt + 1'b1;
            end
            if (i_bad_hdr && (bad_hdr_cnt != '1)) begin
                bad_hdr_cnt <= bad_hdr_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (i_reg_addr)
            REG_CTRL:        rd_mux[0] = o_bypass;
            REG_STATUS:      rd_mux[0] = i_block_lock;
            REG_SLIP_CNT:    rd_mux    = slip_cnt;
            REG_BAD_HDR_CNT: rd_mux    = bad_hdr_cnt;
            default:         rd_mux    = '0;
        endcase
    end

    // read data lands one cycle after the strobe and holds until the next read
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_rdata <= '0;
        end else if (i_reg_rd) begin
            o_reg_rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== pcs_rx_top.sv ====
// ==============================
// 10GBASE-R receive pcs front end
// ==============================
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_top #(
    parameter int GOOD_HDR_COUNT = 64,
    parameter int BAD_HDR_LIMIT  = 16
) (
    input  wire                        i_clk,
    input  wire                        i_reset,
    input  wire pcs_rx_pkg::raw_word_t  i_word,
    input  wire                        i_word_valid,
    output pcs_rx_pkg::block_t         o_block,
    output logic                       o_block_valid,
    output logic                       o_block_lock,
    input  wire                        i_reg_wr,
    input  wire                        i_reg_rd,
    input  wire pcs_rx_pkg::reg_addr_t  i_reg_addr,
    input  wire pcs_rx_pkg::reg_data_t  i_reg_wdata,
    output pcs_rx_pkg::reg_data_t      o_reg_rdata
);

    import pcs_rx_pkg::*;

    // aligned blocks, one cycle behind the input words
    block_t aligned_block;
    logic   aligned_valid;
    logic   slip;
    logic   bad_hdr;
    logic   bypass;

    block_aligner u_aligner (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_word        (i_word),
        .i_word_valid  (i_word_valid),
        .i_slip        (slip),
        .o_block       (aligned_block),
        .o_block_valid (aligned_valid)
    );

    // only the sync header matters for lock
    lock_fsm #(
        .GOOD_HDR_COUNT (GOOD_HDR_COUNT),
        .BAD_HDR_LIMIT  (BAD_HDR_LIMIT)
    ) u_lock (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_header     (aligned_block.header),
        .i_valid      (aligned_valid),
        .o_slip       (slip),
        .o_block_lock (o_block_lock),
        .o_bad_hdr    (bad_hdr)
    );

    // second pipeline stage, so output valid trails i_word_valid by two cycles
    descrambler u_descrambler (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_block  (aligned_block),
        .i_valid  (aligned_valid),
        .i_bypass (bypass),
        .o_block  (o_block),
        .o_valid  (o_block_valid)
    );

    pcs_rx_regs u_regs (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_reg_wr     (i_reg_wr),
        .i_reg_rd     (i_reg_rd),
        .i_reg_addr   (i_reg_addr),
        .i_reg_wdata  (i_reg_wdata),
        .o_reg_rdata  (o_reg_rdata),
        .i_block_lock (o_block_lock),
        .i_slip       (slip),
        .i_bad_hdr    (bad_hdr),
        .o_bypass     (bypass)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive pcs testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pcs_rx -f flist.f -o sim_pcs_rx
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_pcs_rx)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

// ==== tb_pcs_rx.sv ====
// ==============================
// receive pcs testbench
// stream model, offset injection, tests
// ==============================
`timescale 1ns/1ns
`default_nettype none

module tb_pcs_rx;

    import pcs_rx_pkg::*;

    localparam int          GOOD_HDRS = 64;
    localparam int          BAD_LIMIT = 16;
    localparam logic [31:0] SEED      = 32'h942305ab;
    localparam int          LOCK_WAIT = 40000;

    logic      clk;
    logic      reset;
    raw_word_t word;
    logic      word_valid;
    block_t    out_block;
    logic      out_valid;
    logic      block_lock;
    logic      reg_wr;
    logic      reg_rd;
    reg_addr_t reg_addr;
    reg_data_t reg_wdata;
    reg_data_t reg_rdata;
    int        chk_errors;
    int        chk_checked;
    int        chk_count;
    int        chk_lock_idx;

    // stream model state
    logic        bitq[$];
    logic [57:0] scr_hist;
    int          gen_idx;
    int          bad_lo;
    int          bad_hi;
    int          inject_k;
    raw_word_t   feed_word;
    logic        feed_on;
    logic        bypass_mode;

    int   tb_errors;
    int   tests_run;
    int   tests_failed;
    logic aborted;

    pcs_rx_top #(
        .GOOD_HDR_COUNT (GOOD_HDRS),
        .BAD_HDR_LIMIT  (BAD_LIMIT)
    ) u_dut (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_word        (word),
        .i_word_valid  (word_valid),
        .o_block       (out_block),
        .o_block_valid (out_valid),
        .o_block_lock  (block_lock),
        .i_reg_wr      (reg_wr),
        .i_reg_rd      (reg_rd),
        .i_reg_addr    (reg_addr),
        .i_reg_wdata   (reg_wdata),
        .o_reg_rdata   (reg_rdata)
    );

    pcs_rx_checker u_check (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_word_valid  (word_valid),
        .i_block       (out_block),
        .i_block_valid (out_valid),
        .i_block_lock  (block_lock),
        .i_bypass_mode (bypass_mode),
        .o_errors      (chk_errors),
        .o_checked     (chk_checked),
        .o_count       (chk_count),
        .o_lock_idx    (chk_lock_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one block goes on the line with the header bits first and then the payload LSB first
    task automatic gen_block();
        block_t  plain;
        block_t  scr;
        header_t hdr;
        logic    s;
        if ((gen_idx >= bad_lo) && (gen_idx < bad_hi)) begin
            hdr = ($urandom_range(0, 1) != 0) ? 2'b11 : 2'b00;
        end else begin
            hdr = ($urandom_range(0, 1) != 0) ? HDR_CTRL : HDR_DATA;
        end
        plain.header  = hdr;
        plain.payload = {$urandom, $urandom};
        scr.header    = hdr;
        // the scrambler is x^58 + x^39 + 1 and scr_hist[0] holds the newest scrambled bit
        for (int i = 0; i < PAYLOAD_W; i++) begin
            s = plain.payload[i] ^ scr_hist[38] ^ scr_hist[57];
            scr.payload[i] = s;
            scr_hist = {scr_hist[56:0], s};
        end
        bitq.push_back(hdr[0]);
        bitq.push_back(hdr[1]);
        for (int i = 0; i < PAYLOAD_W; i++) begin
            bitq.push_back(scr.payload[i]);
        end
        u_check.add_expected(plain, scr);
        gen_idx++;
    endtask

    task automatic make_word(output raw_word_t w);
        while (bitq.size() < BLOCK_W) begin
            gen_block();
        end
        for (int i = 0; i < BLOCK_W; i++) begin
            w[i] = bitq.pop_front();
        end
    endtask

    // words go out at random on about three cycles in four
    always @(posedge clk) begin
        #1;
        if (feed_on && ($urandom_range(0, 3) != 0)) begin
            make_word(feed_word);
            word       = feed_word;
            word_valid = 1'b1;
        end else begin
            word_valid = 1'b0;
        end
    end

    function automatic int total_errors();
        return tb_errors + chk_errors;
    endfunction

    task automatic set_feed(input logic on);
        @(negedge clk);
        feed_on = on;
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge clk);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // read data is registered on the edge after the strobe
    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge clk);
        #1;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge clk);
        #1;
        reg_rd = 1'b0;
        data   = reg_rdata;
    endtask

    task automatic check_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t got;
        reg_read(addr, got);
        if (got !== exp) begin
            $display("[ERROR] o_reg_rdata %s exp 0x%h got 0x%h", name, exp, got);
            tb_errors++;
        end
    endtask

    task automatic wait_lock(input logic level, input int limit, output logic ok);
        int n;
        n = 0;
        while ((block_lock !== level) && (n < limit)) begin
            @(negedge clk);
            n++;
        end
        ok = (block_lock === level);
        if (!ok) begin
            $display("timeout: block lock did not go to %0d within %0d cycles", level, limit);
            aborted = 1'b1;
        end
    endtask

    task automatic wait_count(input int target, input int limit, output logic dropped);
        int n;
        n       = 0;
        dropped = 1'b0;
        while ((chk_count < target) && (n < limit)) begin
            @(negedge clk);
            if (block_lock !== 1'b1) begin
                dropped = 1'b1;
            end
            n++;
        end
        if (chk_count < target) begin
            $display("timeout: output stopped at %0d blocks, waiting for %0d", chk_count, target);
            aborted = 1'b1;
        end
    endtask

    // lock windows run back to back from the block that completed lock
    function automatic int next_window_start(input int from);
        int first;
        int j;
        first = chk_lock_idx + 1;
        j     = (from - first + GOOD_HDRS - 1) / GOOD_HDRS;
        return first + j * GOOD_HDRS;
    endfunction

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (aborted || (total_errors() != err_before)) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    task automatic run_clean(input int blocks);
        int   c0;
        logic dropped;
        c0 = chk_checked;
        wait_count(chk_count + blocks, 20 * blocks, dropped);
        if (dropped) begin
            $display("block lock dropped while the data was clean");
            tb_errors++;
        end
        if (!aborted && (chk_checked == c0)) begin
            $display("no output block was compared");
            tb_errors++;
        end
    endtask

    task automatic test_regs();
        int e0;
        e0 = total_errors();
        check_reg(REG_CTRL, 16'h0, "REG_CTRL");
        check_reg(REG_STATUS, 16'h0, "REG_STATUS");
        check_reg(REG_SLIP_CNT, 16'h0, "REG_SLIP_CNT");
        check_reg(REG_BAD_HDR_CNT, 16'h0, "REG_BAD_HDR_CNT");
        reg_write(REG_CTRL, 16'h1);
        check_reg(REG_CTRL, 16'h1, "REG_CTRL");
        reg_write(REG_CTRL, 16'h0);
        report_test("register access", e0);
    endtask

    task automatic test_acquire();
        int   e0;
        logic ok;
        e0 = total_errors();
        set_feed(1'b1);
        wait_lock(1'b1, LOCK_WAIT, ok);
        if (ok) begin
            check_reg(REG_STATUS, 16'h1, "REG_STATUS");
            // every slip moves the offset by one from zero
            check_reg(REG_SLIP_CNT, reg_data_t'(inject_k), "REG_SLIP_CNT");
        end
        report_test("acquisition", e0);
    endtask

    task automatic test_payload();
        int e0;
        e0 = total_errors();
        run_clean(300);
        report_test("payload recovery", e0);
    endtask

    task automatic test_lock_loss();
        int        e0;
        int        w;
        logic      ok;
        logic      dropped;
        reg_data_t base_bad;
        reg_data_t base_slip;
        e0 = total_errors();
        reg_read(REG_BAD_HDR_CNT, base_bad);
        // one short of the limit and all inside one window
        w = next_window_start(gen_idx + 2);
        @(negedge clk);
        bad_lo = w;
        bad_hi = w + BAD_LIMIT - 1;
        wait_count(w + GOOD_HDRS + 3, 4000, dropped);
        if (dropped) begin
            $display("block lock dropped with fewer bad headers than the limit");
            tb_errors++;
        end
        if (!aborted) begin
            check_reg(REG_BAD_HDR_CNT, base_bad + reg_data_t'(BAD_LIMIT - 1), "REG_BAD_HDR_CNT");
            reg_read(REG_SLIP_CNT, base_slip);
            // now the full limit inside one window
            w = next_window_start(gen_idx + 2);
            @(negedge clk);
            bad_lo = w;
            bad_hi = w + BAD_LIMIT;
            wait_lock(1'b0, 4000, ok);
        end
        if (!aborted) begin
            // hold the input so the next slip cannot come before the read
            set_feed(1'b0);
            repeat (4) @(posedge clk);
            check_reg(REG_SLIP_CNT, base_slip + 16'd1, "REG_SLIP_CNT");
            set_feed(1'b1);
            wait_lock(1'b1, LOCK_WAIT, ok);
        end
        if (!aborted) begin
            // a full turn of 66 offsets brings the aligner back where it was
            check_reg(REG_SLIP_CNT, base_slip + reg_data_t'(BLOCK_W), "REG_SLIP_CNT");
            run_clean(300);
        end
        report_test("lock hold and loss", e0);
    endtask

    task automatic test_bypass();
        int e0;
        e0 = total_errors();
        // mode changes only while the pipeline is empty
        set_feed(1'b0);
        repeat (4) @(posedge clk);
        reg_write(REG_CTRL, 16'h1);
        check_reg(REG_CTRL, 16'h1, "REG_CTRL");
        @(negedge clk);
        bypass_mode = 1'b1;
        set_feed(1'b1);
        run_clean(200);
        set_feed(1'b0);
        repeat (4) @(posedge clk);
        reg_write(REG_CTRL, 16'h0);
        @(negedge clk);
        bypass_mode = 1'b0;
        report_test("descrambler bypass", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        reset        = 1'b1;
        word         = '0;
        word_valid   = 1'b0;
        reg_wr       = 1'b0;
        reg_rd       = 1'b0;
        reg_addr     = '0;
        reg_wdata    = '0;
        feed_on      = 1'b0;
        bypass_mode  = 1'b0;
        scr_hist     = '0;
        gen_idx      = 0;
        bad_lo       = -1;
        bad_hi       = -1;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        // k junk bits ahead of the first block put every boundary k bits into a word
        inject_k = $urandom_range(0, BLOCK_W - 1);
        for (int i = 0; i < inject_k; i++) begin
            bitq.push_back($urandom_range(0, 1) != 0);
        end
        $display("injected bit offset %0d", inject_k);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        test_regs();
        if (!aborted) test_acquire();
        if (!aborted) test_payload();
        if (!aborted) test_lock_loss();
        if (!aborted) test_bypass();
        $display("tests %0d, failed %0d, blocks compared %0d, errors %0d",
                 tests_run, tests_failed, chk_checked, total_errors());
        if (aborted || (tests_failed != 0) || (total_errors() != 0)) begin
            $display("=== FAIL ===");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
